// File: design/usbPacketPkg.sv
package usbPacketPkg;

    // USB packet identifiers in use on this endpoint, with their standard 4-bit codes
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110
    } PacketId;

    // Upper two PID bits of the answer; handshake and data codes overlap on purpose
    typedef logic [1:0] RespCode;

    localparam RespCode RES_ACK   = 2'b00;
    localparam RespCode RES_NAK   = 2'b10;
    localparam RespCode RES_STALL = 2'b11;
    localparam RespCode RES_DATA0 = 2'b00;
    localparam RespCode RES_DATA1 = 2'b10;

    // Answer of the endpoint to one IN token
    // The full PID is {code, 1'b1, !isHandshake}
    typedef struct packed {
        logic    valid;
        logic    isHandshake;
        RespCode code;
    } EpResponse;

    // One token or handshake from the receive parser
    typedef struct packed {
        logic       valid;
        PacketId    pid;
        logic [6:0] addr;
        logic [3:0] endp;
    } RxPacket;

    // One byte of the transmit stream
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
    } TxByte;

endpackage

// File: design/usbEpPkg.sv
package usbEpPkg;

    // Transfer type of the device-to-host direction
    typedef enum logic [1:0] {
        NONE,
        ISOCHRONOUS,
        BULK,
        INTERRUPT
    } EndpointType;

    typedef struct packed {
        logic        isControlEp;
        logic [3:0]  epNum;
        EndpointType epTypeDevOut;
    } EndpointConfig;

    // Application fill side of the endpoint FIFO
    typedef struct packed {
        logic       fillTransDone;
        logic       fillTransSuccess;
        logic       dataValid;
        logic [7:0] data;
    } EpFillIn;

    // Pop side controls, driven by the decoder and the packetizer
    typedef struct packed {
        logic popTransDone;
        logic popTransSuccess;
        logic popData;
    } EpPopIn;

    typedef struct packed {
        logic       dataAvailable;
        logic       isLastPacketByte;
        logic [7:0] data;
    } EpPopOut;

    localparam int EP_ADDR_WID = 9;
    localparam int EP_DATA_WID = 8;
    // Clocks after the last transmitted byte in which an ACK still counts
    localparam int ACK_TIMEOUT_CYCLES = 18;

endpackage

// File: design/bramFifo.sv
`timescale 1ns/1ns

module bramFifo (
    input  logic                                 clk12_i,
    input  logic                                 arstN_i,
    input  usbEpPkg::EpFillIn                    fill_i,
    output logic                                 full_o,
    input  logic                                 popDone_i,
    input  logic                                 popSuccess_i,
    input  logic                                 popData_i,
    output logic                                 dataAvailable_o,
    output logic                                 isLast_o,
    output logic [usbEpPkg::EP_DATA_WID-1:0]     data_o
);
    import usbEpPkg::*;

    // Block RAM for the payload plus one end-of-packet marker per entry
    logic [EP_DATA_WID-1:0] mem [0:2**EP_ADDR_WID-1];
    logic [2**EP_ADDR_WID-1:0] lastMem;

    // Pointers carry one extra bit so that full and empty differ
    logic [EP_ADDR_WID:0] wrPtr;
    logic [EP_ADDR_WID:0] wrCommit;
    logic [EP_ADDR_WID:0] rdPtr;
    logic [EP_ADDR_WID:0] rdCommit;
    logic [EP_ADDR_WID:0] wrNext;

    logic doWrite;
    logic doCommit;
    logic pastLast;
    logic availQ;
    logic lastQ;
    logic [EP_DATA_WID-1:0] dataQ;

    // Popped but uncommitted bytes still occupy space, so fullness uses rdCommit
    assign full_o = (wrPtr[EP_ADDR_WID] != rdCommit[EP_ADDR_WID])
        && (wrPtr[EP_ADDR_WID-1:0] == rdCommit[EP_ADDR_WID-1:0]);

    assign doWrite = fill_i.dataValid && !full_o;
    assign doCommit = fill_i.fillTransDone && fill_i.fillTransSuccess;
    assign wrNext = wrPtr + {{EP_ADDR_WID{1'b0}}, doWrite};

    // The RAM and the marker array are read synchronously at the current read pointer
    always_ff @(posedge clk12_i) begin
        if (doWrite) begin
            mem[wrPtr[EP_ADDR_WID-1:0]] <= fill_i.data;
            // A byte written in the commit cycle closes the packet itself
            lastMem[wrPtr[EP_ADDR_WID-1:0]] <= doCommit;
        end else if (doCommit && wrPtr != wrCommit) begin
            lastMem[wrPtr[EP_ADDR_WID-1:0] - 1'b1] <= 1'b1;
        end
        dataQ <= mem[rdPtr[EP_ADDR_WID-1:0]];
        lastQ <= lastMem[rdPtr[EP_ADDR_WID-1:0]];
    end

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtr <= '0;
            wrCommit <= '0;
            rdPtr <= '0;
            rdCommit <= '0;
            pastLast <= 1'b0;
            availQ <= 1'b0;
        end else begin
            // On the fill side a commit publishes the packet and a discard drops it
            if (fill_i.fillTransDone) begin
                if (fill_i.fillTransSuccess) begin
                    wrPtr <= wrNext;
                    wrCommit <= wrNext;
                end else begin
                    wrPtr <= wrCommit;
                end
            end else begin
                wrPtr <= wrNext;
            end

            // On the pop side success frees the bytes and failure rewinds to the packet start
            if (popDone_i) begin
                if (popSuccess_i) begin
                    rdCommit <= rdPtr;
                end else begin
                    rdPtr <= rdCommit;
                end
                pastLast <= 1'b0;
            end else if (popData_i) begin
                rdPtr <= rdPtr + 1'b1;
                pastLast <= lastQ;
            end

            // Registered so that it lines up with the RAM output
            availQ <= !popDone_i && (rdPtr != wrCommit) && !pastLast;
        end
    end

    assign dataAvailable_o = availQ;
    assign isLast_o = lastQ;
    assign data_o = dataQ;

endmodule

// File: design/usbEndpointOut.sv
`timescale 1ns/1ns

module usbEndpointOut #(
    parameter usbEpPkg::EndpointConfig EP_CONF
) (
    input  logic                     clk12_i,
    input  logic                     arstN_i,
    input  logic                     gotTransStart_i,
    input  logic                     configEvent_i,
    input  logic                     haltEndpoint_i,
    input  logic                     popDone_i,
    input  logic                     popSuccess_i,
    input  logic                     popData_i,
    input  usbEpPkg::EpFillIn        epFill_i,
    output logic                     epFull_o,
    output usbEpPkg::EpPopOut        popOut_o,
    output usbPacketPkg::EpResponse  resp_o
);
    import usbEpPkg::*;
    import usbPacketPkg::*;

    // The response follows the transaction start by one cycle
    logic respValid;

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            respValid <= 1'b0;
        end else begin
            respValid <= gotTransStart_i;
        end
    end

    generate
        if (!EP_CONF.isControlEp && EP_CONF.epTypeDevOut != NONE) begin : genFifoEp
            logic toggle;
            logic fifoAvail;
            logic awaitRam;
            logic popHs;
            logic hasData;
            logic halted;

            if (EP_CONF.epTypeDevOut == ISOCHRONOUS) begin : genIsoToggle
                // Isochronous data is always sent as DATA0
                assign toggle = 1'b0;
            end else begin : genSeqToggle
                always_ff @(posedge clk12_i or negedge arstN_i) begin
                    if (!arstN_i) begin
                        toggle <= 1'b0;
                    end else if (configEvent_i) begin
                        toggle <= 1'b0;
                    end else if (popDone_i && popSuccess_i) begin
                        toggle <= !toggle;
                    end
                end
            end

            // Hide the stale RAM word for one cycle after every pop
            assign popHs = popOut_o.dataAvailable && popData_i;

            always_ff @(posedge clk12_i or negedge arstN_i) begin
                if (!arstN_i) begin
                    awaitRam <= 1'b0;
                    hasData <= 1'b0;
                    halted <= 1'b0;
                end else begin
                    awaitRam <= popHs;
                    // Availability and halt are frozen for the whole transaction
                    if (gotTransStart_i) begin
                        hasData <= fifoAvail;
                        halted <= haltEndpoint_i;
                    end
                end
            end

            bramFifo u_fifo (
                .clk12_i        (clk12_i),
                .arstN_i        (arstN_i),
                .fill_i         (epFill_i),
                .full_o         (epFull_o),
                .popDone_i      (popDone_i),
                .popSuccess_i   (popSuccess_i),
                .popData_i      (popHs),
                .dataAvailable_o(fifoAvail),
                .isLast_o       (popOut_o.isLastPacketByte),
                .data_o         (popOut_o.data)
            );

            assign popOut_o.dataAvailable = fifoAvail && !awaitRam;

            // NAK and DATA1 share the upper code bit, so one mux covers both
            assign resp_o = '{
                valid:       respValid,
                isHandshake: halted || !hasData,
                code:        halted ? RES_STALL
                           : (!hasData ? RES_NAK : (toggle ? RES_DATA1 : RES_DATA0))
            };
        end else begin : genStallEp
            // A control or unused endpoint stalls every IN token
            assign resp_o = '{valid: respValid, isHandshake: 1'b1, code: RES_STALL};
            assign popOut_o = '0;
            assign epFull_o = 1'b1;
        end
    endgenerate

endmodule

// File: design/tokenDecoder.sv
`timescale 1ns/1ns

module tokenDecoder #(
    parameter usbEpPkg::EndpointConfig EP_CONF
) (
    input  logic                   clk12_i,
    input  logic                   arstN_i,
    input  usbPacketPkg::RxPacket  rxPacket_i,
    input  logic [6:0]             deviceAddr_i,
    input  logic                   dataSent_i,
    output logic                   gotTransStart_o,
    output logic                   popDone_o,
    output logic                   popSuccess_o
);
    import usbPacketPkg::*;
    import usbEpPkg::*;

    localparam int CNT_WID = $clog2(ACK_TIMEOUT_CYCLES + 1);

    typedef enum logic {
        IDLE,
        AWAIT_ACK
    } DecState;

    DecState state;
    logic [CNT_WID-1:0] ackTimer;
    logic isOurIn;
    logic isAck;

    // Only IN tokens addressed to this device and endpoint start a transaction
    assign isOurIn = rxPacket_i.valid && rxPacket_i.pid == PID_IN
        && rxPacket_i.addr == deviceAddr_i && rxPacket_i.endp == EP_CONF.epNum;

    // Handshakes carry no address, so any ACK counts while armed
    assign isAck = rxPacket_i.valid && rxPacket_i.pid == PID_ACK;

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= IDLE;
            ackTimer <= '0;
            gotTransStart_o <= 1'b0;
            popDone_o <= 1'b0;
            popSuccess_o <= 1'b0;
        end else begin
            gotTransStart_o <= isOurIn;
            popDone_o <= 1'b0;
            popSuccess_o <= 1'b0;
            case (state)
                IDLE: begin
                    // Arm once the last byte of a data packet has gone out
                    if (dataSent_i) begin
                        state <= AWAIT_ACK;
                        ackTimer <= CNT_WID'(ACK_TIMEOUT_CYCLES - 1);
                    end
                end
                AWAIT_ACK: begin
                    if (isAck) begin
                        popDone_o <= 1'b1;
                        popSuccess_o <= 1'b1;
                        state <= IDLE;
                    end else if (ackTimer == '0) begin
                        // No ACK in time, so the packet is rolled back for a resend
                        popDone_o <= 1'b1;
                        state <= IDLE;
                    end else begin
                        ackTimer <= ackTimer - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/txPacketizer.sv
`timescale 1ns/1ns

module txPacketizer (
    input  logic                     clk12_i,
    input  logic                     arstN_i,
    input  usbPacketPkg::EpResponse  resp_i,
    input  usbEpPkg::EpPopOut        popIn_i,
    output logic                     popData_o,
    output logic                     dataSent_o,
    output usbPacketPkg::TxByte      txByte_o,
    input  logic                     txReady_i
);
    import usbPacketPkg::*;
    import usbEpPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        PID,
        PAYLOAD,
        CRC_LO,
        CRC_HI
    } TxState;

    TxState state;
    EpResponse respQ;
    PacketId pid;
    logic [15:0] crc;

    // USB CRC16 over one byte, LSB first, with the reflected form of 0x8005
    function automatic logic [15:0] crc16Byte(input logic [15:0] crcIn, input logic [7:0] d);
        logic [15:0] c;
        c = crcIn;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ 16'hA001;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Rebuild the full PID from the two response code bits
    assign pid = PacketId'({respQ.code, 1'b1, !respQ.isHandshake});

    // A payload byte moves only while the endpoint offers one and the sink takes it
    assign popData_o = state == PAYLOAD && popIn_i.dataAvailable && txReady_i;
    assign dataSent_o = state == CRC_HI && txReady_i;

    always_comb begin
        txByte_o = '0;
        case (state)
            PID: begin
                txByte_o = '{valid: 1'b1, data: {~pid, pid}, last: respQ.isHandshake};
            end
            PAYLOAD: begin
                txByte_o = '{valid: popIn_i.dataAvailable, data: popIn_i.data, last: 1'b0};
            end
            // The CRC goes out complemented, low byte first
            CRC_LO: txByte_o = '{valid: 1'b1, data: ~crc[7:0], last: 1'b0};
            CRC_HI: txByte_o = '{valid: 1'b1, data: ~crc[15:8], last: 1'b1};
            default: txByte_o = '0;
        endcase
    end

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= IDLE;
            respQ <= '0;
            crc <= 16'hFFFF;
        end else begin
            case (state)
                IDLE: begin
                    // Responses are taken only here, so tokens during a send are lost
                    if (resp_i.valid) begin
                        respQ <= resp_i;
                        crc <= 16'hFFFF;
                        state <= PID;
                    end
                end
                PID: begin
                    if (txReady_i) begin
                        state <= respQ.isHandshake ? IDLE : PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (popData_o) begin
                        crc <= crc16Byte(crc, popIn_i.data);
                        if (popIn_i.isLastPacketByte) begin
                            state <= CRC_LO;
                        end
                    end
                end
                CRC_LO: begin
                    if (txReady_i) begin
                        state <= CRC_HI;
                    end
                end
                CRC_HI: begin
                    if (txReady_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/usbEpOutPath.sv
`timescale 1ns/1ns

module usbEpOutPath #(
    parameter usbEpPkg::EndpointConfig EP_CONF = '{
        isControlEp:  1'b0,
        epNum:        4'd1,
        epTypeDevOut: usbEpPkg::BULK
    }
) (
    input  logic                   clk12_i,
    input  logic                   arstN_i,
    input  usbPacketPkg::RxPacket  rxPacket_i,
    input  logic [6:0]             deviceAddr_i,
    input  logic                   configEvent_i,
    input  logic                   haltEndpoint_i,
    input  usbEpPkg::EpFillIn      epFill_i,
    output logic                   epFull_o,
    output usbPacketPkg::TxByte    txByte_o,
    input  logic                   txReady_i
);
    import usbEpPkg::*;
    import usbPacketPkg::*;

    logic gotTransStart;
    logic dataSent;
    // Pop controls come from two places: the decoder ends, the packetizer pulls
    EpPopIn popIn;
    EpPopOut popOut;
    EpResponse resp;

    tokenDecoder #(.EP_CONF(EP_CONF)) u_decoder (
        .clk12_i        (clk12_i),
        .arstN_i        (arstN_i),
        .rxPacket_i     (rxPacket_i),
        .deviceAddr_i   (deviceAddr_i),
        .dataSent_i     (dataSent),
        .gotTransStart_o(gotTransStart),
        .popDone_o      (popIn.popTransDone),
        .popSuccess_o   (popIn.popTransSuccess)
    );

    usbEndpointOut #(.EP_CONF(EP_CONF)) u_endpoint (
        .clk12_i        (clk12_i),
        .arstN_i        (arstN_i),
        .gotTransStart_i(gotTransStart),
        .configEvent_i  (configEvent_i),
        .haltEndpoint_i (haltEndpoint_i),
        .popDone_i      (popIn.popTransDone),
        .popSuccess_i   (popIn.popTransSuccess),
        .popData_i      (popIn.popData),
        .epFill_i       (epFill_i),
        .epFull_o       (epFull_o),
        .popOut_o       (popOut),
        .resp_o         (resp)
    );

    txPacketizer u_packetizer (
        .clk12_i   (clk12_i),
        .arstN_i   (arstN_i),
        .resp_i    (resp),
        .popIn_i   (popOut),
        .popData_o (popIn.popData),
        .dataSent_o(dataSent),
        .txByte_o  (txByte_o),
        .txReady_i (txReady_i)
    );

endmodule

// File: testbench/usbEpOutPathTb.sv
`timescale 1ns/1ns

module usbEpOutPathTb;
    import usbPacketPkg::*;
    import usbEpPkg::*;

    // Bulk endpoint 2 of a device on address 5
    localparam EndpointConfig TB_EP_CONF = '{
        isControlEp:  1'b0,
        epNum:        4'd2,
        epTypeDevOut: BULK
    };
    localparam logic [6:0] DEV_ADDR = 7'h05;
    localparam int VEC_DEPTH = 512;
    // Cycles in which an ignored token must not bring up a transmit byte
    localparam int WATCH_CYCLES = 40;
    // Longest gap between two transmit bytes before a response counts as lost
    localparam int BYTE_TIMEOUT = 200;

    // Command codes of the vector file
    localparam logic [7:0] CMD_FILL = 8'h01;
    localparam logic [7:0] CMD_TOKEN = 8'h02;
    localparam logic [7:0] CMD_WAIT = 8'h03;
    localparam logic [7:0] CMD_CONFIG = 8'h04;
    localparam logic [7:0] CMD_HALT = 8'h05;
    localparam logic [7:0] CMD_END = 8'hFF;

    logic clk12;
    logic arstN;
    RxPacket rxPacket;
    logic [6:0] deviceAddr;
    logic configEvent;
    logic haltEndpoint;
    EpFillIn epFill;
    logic epFull;
    TxByte txByte;
    logic txReady;

    logic [7:0] vecMem [0:VEC_DEPTH-1];
    logic [7:0] rxBytes [$];
    integer seed = 36030;
    int mismatchCount = 0;
    int failCount = 0;

    usbEpOutPath #(.EP_CONF(TB_EP_CONF)) u_dut (
        .clk12_i       (clk12),
        .arstN_i       (arstN),
        .rxPacket_i    (rxPacket),
        .deviceAddr_i  (deviceAddr),
        .configEvent_i (configEvent),
        .haltEndpoint_i(haltEndpoint),
        .epFill_i      (epFill),
        .epFull_o      (epFull),
        .txByte_o      (txByte),
        .txReady_i     (txReady)
    );

    initial begin
        clk12 = 1'b0;
        forever #50 clk12 = ~clk12;
    end

    // The sink refuses about one byte in four
    initial begin
        txReady = 1'b0;
        forever begin
            @(posedge clk12);
            txReady <= ($random(seed) & 3) != 0;
        end
    end

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        if (got !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // A token or handshake is on the bus for exactly one clock
    task automatic sendToken(input logic [3:0] pidCode, input logic [6:0] tokAddr,
                             input logic [3:0] tokEndp);
        @(posedge clk12);
        rxPacket <= '{valid: 1'b1, pid: PacketId'(pidCode), addr: tokAddr, endp: tokEndp};
        @(posedge clk12);
        rxPacket <= '0;
    endtask

    // Bytes come one per clock from the vector memory and a separate cycle commits or discards them
    task automatic fillPacket(input int base, input int count, input logic commit);
        for (int i = 0; i < count; i++) begin
            @(posedge clk12);
            epFill <= '{fillTransDone: 1'b0, fillTransSuccess: 1'b0, dataValid: 1'b1,
                        data: vecMem[base + i]};
        end
        @(posedge clk12);
        epFill <= '{fillTransDone: 1'b1, fillTransSuccess: commit, dataValid: 1'b0,
                    data: 8'h00};
        @(posedge clk12);
        epFill <= '0;
    endtask

    // A byte moves where valid and ready are both high at the next rising edge
    task automatic collectResponse(output logic ok);
        int idle;
        logic done;
        idle = 0;
        done = 1'b0;
        ok = 1'b1;
        rxBytes.delete();
        while (!done) begin
            @(negedge clk12);
            if (txByte.valid && txReady) begin
                rxBytes.push_back(txByte.data);
                done = txByte.last;
                idle = 0;
            end else begin
                idle++;
                if (idle > BYTE_TIMEOUT) begin
                    $display("Timeout at %0t ns: response did not finish", $time);
                    failCount++;
                    ok = 1'b0;
                    done = 1'b1;
                end
            end
        end
    endtask

    task automatic watchQuiet(input int cmdPos);
        repeat (WATCH_CYCLES) begin
            @(negedge clk12);
            if (txByte.valid) begin
                $display("Unexpected transmit byte %h at %0t ns after the token at word %0d",
                         txByte.data, $time, cmdPos);
                failCount++;
                return;
            end
        end
    endtask

    initial begin
        int pc;
        int count;
        logic running;
        logic ok;
        arstN = 1'b0;
        rxPacket = '0;
        deviceAddr = DEV_ADDR;
        configEvent = 1'b0;
        haltEndpoint = 1'b0;
        epFill = '0;
        $readmemh("testbench/usbEpOutPath_vectors.txt", vecMem);
        repeat (5) @(posedge clk12);
        arstN <= 1'b1;
        @(negedge clk12);
        checkValue(txByte.valid, 1'b0, "transmit valid after reset");
        checkValue(epFull, 1'b0, "FIFO full after reset");

        pc = 0;
        running = 1'b1;
        while (running && pc < VEC_DEPTH) begin
            case (vecMem[pc])
                CMD_FILL: begin
                    count = vecMem[pc + 2];
                    fillPacket(pc + 3, count, vecMem[pc + 1][0]);
                    pc = pc + 3 + count;
                end
                CMD_TOKEN: begin
                    count = vecMem[pc + 4];
                    sendToken(vecMem[pc + 1][3:0], vecMem[pc + 2][6:0], vecMem[pc + 3][3:0]);
                    if (count == 0) begin
                        watchQuiet(pc);
                    end else begin
                        collectResponse(ok);
                        // A lost response is already counted, so its bytes are not compared
                        if (ok) begin
                            checkValue(rxBytes.size(), count,
                                       $sformatf("length of response to word %0d", pc));
                            // Payload and CRC must match even after random sink stalls
                            for (int i = 0; i < count && i < rxBytes.size(); i++) begin
                                checkValue(rxBytes[i], vecMem[pc + 5 + i],
                                           $sformatf("byte %0d of response to word %0d", i, pc));
                            end
                        end
                    end
                    pc = pc + 5 + count;
                end
                CMD_WAIT: begin
                    repeat (vecMem[pc + 1]) @(posedge clk12);
                    pc = pc + 2;
                end
                CMD_CONFIG: begin
                    @(posedge clk12);
                    configEvent <= 1'b1;
                    @(posedge clk12);
                    configEvent <= 1'b0;
                    pc = pc + 1;
                end
                CMD_HALT: begin
                    @(posedge clk12);
                    haltEndpoint <= vecMem[pc + 1][0];
                    pc = pc + 2;
                end
                CMD_END: running = 1'b0;
                default: begin
                    $display("Unknown command %h at vector word %0d", vecMem[pc], pc);
                    failCount++;
                    running = 1'b0;
                end
            endcase
        end
        if (running) begin
            $display("Vector file has no end marker");
            failCount++;
        end

        repeat (4) @(posedge clk12);
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: usbEpOutPath.f
design/usbPacketPkg.sv
design/usbEpPkg.sv
design/bramFifo.sv
design/usbEndpointOut.sv
design/tokenDecoder.sv
design/txPacketizer.sv
design/usbEpOutPath.sv
testbench/usbEpOutPathTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= usbEpOutPathTb
FILELIST  ?= usbEpOutPath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/usbEpOutPath_vectors.txt
// Words: 01 fill (commit, count, bytes) | 02 token (pid, addr, endp, count, expected bytes)
// 03 wait (cycles) | 04 config event | 05 halt (level) | FF end; all values are hex
02 9 05 2 01 5A               // Empty endpoint answers NAK
01 0 02 11 22                 // Discarded fill leaves nothing to send
02 9 05 2 01 5A
01 1 02 01 02
02 9 05 2 05 C3 01 02 7E 1E   // DATA0, payload and CRC16
02 2 00 0 00                  // ACK releases the packet
01 1 01 A5
02 9 05 2 04 4B A5 80 C4      // Toggle moved on to DATA1
03 1E                         // No ACK so the FIFO rolls back
02 9 05 2 04 4B A5 80 C4      // Same packet with the same toggle
02 2 00 0 00
01 1 01 3C
02 9 05 2 04 C3 3C 40 AE
02 2 00 0 00
01 1 02 01 02
04                            // Config event forces DATA0
02 9 05 2 05 C3 01 02 7E 1E
02 2 00 0 00
01 1 01 A5
05 1
02 9 05 2 01 1E               // STALL while halted
05 0
02 9 05 2 04 4B A5 80 C4      // Queued packet survives the stall
02 2 00 0 00
02 9 06 2 00                  // Other device address
02 9 05 3 00                  // Other endpoint number
02 1 05 2 00                  // OUT token
02 9 05 2 01 5A
FF
